/* bench/cpu_properties.sv */
// Assertions on the request unit handshake and the strobe and busy bus

`default_nettype none

module cpu_properties (
  input logic           clk,
  input logic           rst_i,
  input logic           req_valid_i,
  input logic           req_ready_i,
  input logic           rsp_valid_i,
  input logic           bus_read_i,
  input logic           bus_write_i,
  input logic           bus_busy_i,
  input cpu_pkg::word_t bus_adr_i
);

  logic outstanding_q;
  logic accept;
  logic strobe;
  int   fail_count;

  assign accept = req_valid_i && req_ready_i;
  assign strobe = bus_read_i || bus_write_i;

  initial begin
    fail_count = 0;
  end

  // Set between acceptance and the response pulse
  always_ff @(posedge clk) begin
    if (rst_i) begin
      outstanding_q <= 1'b0;
    end else if (accept) begin
      outstanding_q <= 1'b1;
    end else if (rsp_valid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  read_write_exclusive: assert property (@(posedge clk) disable iff (rst_i)
    !(bus_read_i && bus_write_i))
    else begin
      fail_count++;
      $error("bus read and write strobes high together");
    end

  strobe_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
    strobe |=> !strobe)
    else begin
      fail_count++;
      $error("bus strobe held longer than one cycle");
    end

  address_stable: assert property (@(posedge clk) disable iff (rst_i)
    bus_busy_i |-> $stable(bus_adr_i))
    else begin
      fail_count++;
      $error("bus address changed while busy");
    end

  // Response must come back before the next request is taken
  accept_when_free: assert property (@(posedge clk) disable iff (rst_i)
    accept |-> !outstanding_q)
    else begin
      fail_count++;
      $error("request accepted before previous response");
    end

  response_when_pending: assert property (@(posedge clk) disable iff (rst_i)
    rsp_valid_i |-> outstanding_q)
    else begin
      fail_count++;
      $error("response without an accepted request");
    end

endmodule

bind request_unit cpu_properties u_props (
  .clk         (clk),
  .rst_i       (rst_i),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .bus_read_i  (bus_read_o),
  .bus_write_i (bus_write_o),
  .bus_busy_i  (bus_busy_i),
  .bus_adr_i   (bus_adr_o)
);

`default_nettype wire

/* bench/cpu_tb.sv */
// Testbench for the multicycle RV32I processor with a wait-state bus memory

`default_nettype none

module cpu_tb;

  logic           clk;
  logic           rst_i;
  logic           bus_busy_i;
  cpu_pkg::word_t bus_dat_i;
  cpu_pkg::word_t bus_adr_o;
  cpu_pkg::word_t bus_dat_o;
  logic           bus_read_o;
  logic           bus_write_o;
  logic           halt_o;

  cpu_pkg::word_t mem [1024];
  integer         seed;
  int             errors;
  int             test_errors;
  int             tests_run;
  int             prog_ptr;
  int             strobe_count;
  logic           first_seen;
  logic           first_read;
  cpu_pkg::word_t first_adr;

  // Bus outputs sampled mid cycle
  logic           s_rst;
  logic           s_read;
  logic           s_write;
  cpu_pkg::word_t s_adr;
  cpu_pkg::word_t s_dat;

  int             busy_left;
  logic           pend_write;
  cpu_pkg::word_t pend_adr;

  cpu_top dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_busy_i  (bus_busy_i),
    .bus_dat_i   (bus_dat_i),
    .bus_adr_o   (bus_adr_o),
    .bus_dat_o   (bus_dat_o),
    .bus_read_o  (bus_read_o),
    .bus_write_o (bus_write_o),
    .halt_o      (halt_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(negedge clk) begin
    s_rst   = rst_i;
    s_read  = bus_read_o;
    s_write = bus_write_o;
    s_adr   = bus_adr_o;
    s_dat   = bus_dat_o;
  end

  // Bus memory with 1 to 4 busy cycles per strobe and data valid in the cycle busy drops
  initial begin
    bus_busy_i   = 1'b0;
    bus_dat_i    = '0;
    busy_left    = 0;
    pend_write   = 1'b0;
    pend_adr     = '0;
    strobe_count = 0;
    first_seen   = 1'b0;
    first_read   = 1'b0;
    first_adr    = '0;
    s_rst        = 1'b1;
    s_read       = 1'b0;
    s_write      = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (s_rst) begin
        bus_busy_i = 1'b0;
        busy_left  = 0;
      end else if (busy_left > 0) begin
        busy_left = busy_left - 1;
        if (busy_left == 0) begin
          bus_busy_i = 1'b0;
          if (!pend_write) begin
            bus_dat_i = mem[pend_adr[11:2]];
          end
        end
      end else if (s_read || s_write) begin
        strobe_count = strobe_count + 1;
        if (!first_seen) begin
          first_seen = 1'b1;
          first_adr  = s_adr;
          first_read = s_read;
        end
        pend_adr   = s_adr;
        pend_write = s_write;
        if (s_write) begin
          mem[s_adr[11:2]] = s_dat;
        end
        busy_left  = 1 + int'({$random(seed)} % 4);
        bus_busy_i = 1'b1;
        bus_dat_i  = 32'hbad0_bad0;
      end else begin
        bus_dat_i = 32'hbad0_bad0;
      end
    end
  end

  // RV32I encodings
  function automatic cpu_pkg::word_t alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
  endfunction

  function automatic cpu_pkg::word_t alu_ri(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, cpu_pkg::OPC_OP_IMM};
  endfunction

  function automatic cpu_pkg::word_t load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, cpu_pkg::OPC_LOAD};
  endfunction

  function automatic cpu_pkg::word_t store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                                input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OPC_STORE};
  endfunction

  function automatic cpu_pkg::word_t branch_to(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::OPC_BRANCH};
  endfunction

  function automatic cpu_pkg::word_t upper(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic cpu_pkg::word_t jal_to(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::OPC_JAL};
  endfunction

  function automatic cpu_pkg::word_t jalr_to(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, cpu_pkg::OPC_JALR};
  endfunction

  function automatic cpu_pkg::word_t ebreak_instr();
    return 32'h0010_0073;
  endfunction

  task automatic check(input string name, input cpu_pkg::word_t got,
                       input cpu_pkg::word_t want);
    if (got !== want) begin
      $display("error: %s got %h expected %h", name, got, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic emit(input cpu_pkg::word_t instr);
    mem[prog_ptr] = instr;
    prog_ptr++;
  endtask

  // Fill every word with its own index so stale reads stand out
  task automatic clear_memory();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'hdead_0000 | 32'(i);
    end
    prog_ptr = 0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_i      = 1'b1;
    first_seen = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_i = 1'b0;
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!halt_o && cycles < 2000);
    if (!halt_o) begin
      $display("test failure: core did not halt within 2000 cycles");
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic reset_test();
    clear_memory();
    emit(ebreak_instr());
    apply_reset();
    @(negedge clk);
    check("bus_read_o", {31'b0, bus_read_o}, 32'h0);
    check("bus_write_o", {31'b0, bus_write_o}, 32'h0);
    check("halt_o", {31'b0, halt_o}, 32'h0);
    wait_halt();
    check("first strobe is read", {31'b0, first_read}, 32'h1);
    check("bus_adr_o of first strobe", first_adr, 32'h0);
    finish_test("reset");
  endtask

  task automatic alu_test();
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t ops [19];
    cpu_pkg::word_t want [19];
    a = 32'h0000_0123;
    b = 32'hffff_fff9;
    ops[0]   = alu_rr(7'h00, 3'b000, 5'd10, 5'd1, 5'd2);
    want[0]  = a + b;
    ops[1]   = alu_rr(7'h20, 3'b000, 5'd10, 5'd1, 5'd2);
    want[1]  = a - b;
    ops[2]   = alu_rr(7'h00, 3'b100, 5'd10, 5'd1, 5'd2);
    want[2]  = a ^ b;
    ops[3]   = alu_rr(7'h00, 3'b110, 5'd10, 5'd1, 5'd2);
    want[3]  = a | b;
    ops[4]   = alu_rr(7'h00, 3'b111, 5'd10, 5'd1, 5'd2);
    want[4]  = a & b;
    ops[5]   = alu_rr(7'h00, 3'b010, 5'd10, 5'd2, 5'd1);
    want[5]  = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    ops[6]   = alu_rr(7'h00, 3'b011, 5'd10, 5'd2, 5'd1);
    want[6]  = (b < a) ? 32'd1 : 32'd0;
    ops[7]   = alu_rr(7'h00, 3'b001, 5'd10, 5'd1, 5'd3);
    want[7]  = a << 5;
    ops[8]   = alu_rr(7'h00, 3'b101, 5'd10, 5'd2, 5'd3);
    want[8]  = b >> 5;
    ops[9]   = alu_rr(7'h20, 3'b101, 5'd10, 5'd2, 5'd3);
    want[9]  = {{5{b[31]}}, b[31:5]};
    ops[10]  = alu_ri(3'b000, 5'd10, 5'd1, 12'he00);
    want[10] = a + 32'hffff_fe00;
    ops[11]  = alu_ri(3'b010, 5'd10, 5'd2, 12'hffa);
    want[11] = ($signed(b) < $signed(32'hffff_fffa)) ? 32'd1 : 32'd0;
    ops[12]  = alu_ri(3'b011, 5'd10, 5'd1, 12'hfff);
    want[12] = (a < 32'hffff_ffff) ? 32'd1 : 32'd0;
    ops[13]  = alu_ri(3'b100, 5'd10, 5'd2, 12'h555);
    want[13] = b ^ 32'h0000_0555;
    ops[14]  = alu_ri(3'b110, 5'd10, 5'd1, 12'hff0);
    want[14] = a | 32'hffff_fff0;
    ops[15]  = alu_ri(3'b111, 5'd10, 5'd2, 12'h0f0);
    want[15] = b & 32'h0000_00f0;
    ops[16]  = alu_ri(3'b001, 5'd10, 5'd1, 12'd20);
    want[16] = a << 20;
    ops[17]  = alu_ri(3'b101, 5'd10, 5'd2, 12'd3);
    want[17] = b >> 3;
    ops[18]  = alu_ri(3'b101, 5'd10, 5'd2, {7'h20, 5'd3});
    want[18] = {{3{b[31]}}, b[31:3]};
    clear_memory();
    emit(alu_ri(3'b000, 5'd1, 5'd0, 12'h123));
    emit(alu_ri(3'b000, 5'd2, 5'd0, 12'hff9));
    emit(alu_ri(3'b000, 5'd3, 5'd0, 12'd5));
    for (int k = 0; k < 19; k++) begin
      emit(ops[k]);
      emit(store_word(5'd10, 5'd0, 12'h400 + 12'(4 * k)));
    end
    emit(ebreak_instr());
    apply_reset();
    wait_halt();
    for (int k = 0; k < 19; k++) begin
      check($sformatf("alu store %0d", k), mem[256 + k], want[k]);
    end
    finish_test("alu");
  endtask

  task automatic branch_test();
    cpu_pkg::word_t sum;
    cpu_pkg::word_t count;
    cpu_pkg::word_t flags;
    cpu_pkg::word_t neg;
    cpu_pkg::word_t one;
    clear_memory();
    emit(alu_ri(3'b000, 5'd1, 5'd0, 12'd0));
    emit(alu_ri(3'b000, 5'd2, 5'd0, 12'd1));
    emit(alu_ri(3'b000, 5'd3, 5'd0, 12'd11));
    emit(alu_rr(7'h00, 3'b000, 5'd1, 5'd1, 5'd2));
    emit(alu_ri(3'b000, 5'd2, 5'd2, 12'd1));
    emit(branch_to(3'b001, 5'd2, 5'd3, -13'sd8));
    emit(store_word(5'd1, 5'd0, 12'h400));
    emit(alu_ri(3'b000, 5'd4, 5'd0, 12'd0));
    emit(alu_ri(3'b000, 5'd5, 5'd0, 12'd10));
    emit(alu_ri(3'b000, 5'd4, 5'd4, 12'd1));
    emit(branch_to(3'b100, 5'd4, 5'd5, -13'sd4));
    emit(store_word(5'd4, 5'd0, 12'h404));
    // Each not-taken branch sets one flag bit in x8
    emit(alu_ri(3'b000, 5'd6, 5'd0, 12'hfff));
    emit(alu_ri(3'b000, 5'd7, 5'd0, 12'd1));
    emit(alu_ri(3'b000, 5'd8, 5'd0, 12'd0));
    emit(branch_to(3'b110, 5'd6, 5'd7, 13'd8));
    emit(alu_ri(3'b110, 5'd8, 5'd8, 12'd1));
    emit(branch_to(3'b111, 5'd6, 5'd7, 13'd8));
    emit(alu_ri(3'b110, 5'd8, 5'd8, 12'd2));
    emit(branch_to(3'b100, 5'd6, 5'd7, 13'd8));
    emit(alu_ri(3'b110, 5'd8, 5'd8, 12'd4));
    emit(branch_to(3'b101, 5'd6, 5'd7, 13'd8));
    emit(alu_ri(3'b110, 5'd8, 5'd8, 12'd8));
    emit(branch_to(3'b000, 5'd6, 5'd7, 13'd8));
    emit(alu_ri(3'b110, 5'd8, 5'd8, 12'd16));
    emit(store_word(5'd8, 5'd0, 12'h408));
    emit(ebreak_instr());
    apply_reset();
    wait_halt();
    sum = 0;
    for (int i = 1; i <= 10; i++) begin
      sum = sum + 32'(i);
    end
    count = 0;
    do begin
      count = count + 1;
    end while ($signed(count) < 10);
    neg   = 32'hffff_ffff;
    one   = 32'd1;
    flags = 0;
    flags = flags | ((neg < one) ? 32'd0 : 32'd1);
    flags = flags | ((neg >= one) ? 32'd0 : 32'd2);
    flags = flags | (($signed(neg) < $signed(one)) ? 32'd0 : 32'd4);
    flags = flags | (($signed(neg) >= $signed(one)) ? 32'd0 : 32'd8);
    flags = flags | ((neg == one) ? 32'd0 : 32'd16);
    check("bne loop sum", mem[256], sum);
    check("blt loop count", mem[257], count);
    check("branch flags", mem[258], flags);
    finish_test("branch");
  endtask

  // Two rounds, so two different wait-state patterns
  task automatic memory_test();
    cpu_pkg::word_t init [4];
    cpu_pkg::word_t mid;
    for (int round = 0; round < 2; round++) begin
      clear_memory();
      for (int k = 0; k < 4; k++) begin
        init[k]      = $random(seed);
        mem[256 + k] = init[k];
      end
      for (int k = 0; k < 4; k++) begin
        emit(load_word(5'd1, 5'd0, 12'h400 + 12'(4 * k)));
        emit(alu_ri(3'b001, 5'd1, 5'd1, 12'd1));
        emit(alu_ri(3'b000, 5'd1, 5'd1, 12'(k + 1)));
        emit(store_word(5'd1, 5'd0, 12'h480 + 12'(4 * k)));
        emit(load_word(5'd2, 5'd0, 12'h480 + 12'(4 * k)));
        emit(alu_ri(3'b100, 5'd2, 5'd2, 12'h0ff));
        emit(store_word(5'd2, 5'd0, 12'h400 + 12'(4 * k)));
      end
      emit(ebreak_instr());
      apply_reset();
      wait_halt();
      for (int k = 0; k < 4; k++) begin
        mid = (init[k] << 1) + 32'(k + 1);
        check($sformatf("mem[%0d]", 288 + k), mem[288 + k], mid);
        check($sformatf("mem[%0d]", 256 + k), mem[256 + k], mid ^ 32'h0000_00ff);
      end
    end
    finish_test("memory");
  endtask

  task automatic jump_test();
    cpu_pkg::word_t target;
    clear_memory();
    emit(upper(cpu_pkg::OPC_LUI, 5'd1, 20'h12345));
    emit(upper(cpu_pkg::OPC_AUIPC, 5'd2, 20'h00010));
    emit(jal_to(5'd3, 21'd8));
    emit(alu_ri(3'b000, 5'd9, 5'd9, 12'd1));
    emit(alu_ri(3'b000, 5'd5, 5'd0, 12'h031));
    emit(jalr_to(5'd6, 5'd5, 12'd0));
    // Landing pad for a JALR that ignores bit 0
    for (int k = 6; k < 12; k++) begin
      emit(alu_ri(3'b000, 5'd9, 5'd9, 12'd1));
    end
    emit(jal_to(5'd7, 21'd8));
    emit(alu_ri(3'b000, 5'd9, 5'd9, 12'd1));
    emit(store_word(5'd1, 5'd0, 12'h400));
    emit(store_word(5'd2, 5'd0, 12'h404));
    emit(store_word(5'd3, 5'd0, 12'h408));
    emit(store_word(5'd6, 5'd0, 12'h40c));
    emit(store_word(5'd7, 5'd0, 12'h410));
    emit(store_word(5'd9, 5'd0, 12'h414));
    emit(ebreak_instr());
    apply_reset();
    wait_halt();
    target = (32'h0000_0031 + 32'd0) & ~32'h1;
    check("lui x1", mem[256], {20'h12345, 12'h000});
    check("auipc x2", mem[257], 32'd4 + {20'h00010, 12'h000});
    check("jal link x3", mem[258], 32'd8 + 32'd4);
    check("jalr link x6", mem[259], 32'd20 + 32'd4);
    check("jal link x7", mem[260], target + 32'd4);
    check("skipped x9", mem[261], 32'd0);
    finish_test("jump");
  endtask

  task automatic halt_test();
    int strobes_at_halt;
    int low_cycles;
    clear_memory();
    emit(alu_ri(3'b000, 5'd1, 5'd0, 12'd5));
    emit(store_word(5'd1, 5'd0, 12'h400));
    emit(ebreak_instr());
    apply_reset();
    wait_halt();
    strobes_at_halt = strobe_count;
    low_cycles      = 0;
    repeat (50) begin
      @(negedge clk);
      if (!halt_o) begin
        low_cycles++;
      end
    end
    check("halt_o low cycles", 32'(low_cycles), 32'd0);
    check("strobes after halt", 32'(strobe_count - strobes_at_halt), 32'd0);
    check("stored x1", mem[256], 32'd5);
    finish_test("halt");
  endtask

  initial begin
    int num_tests;
    int limit;
    num_tests = 6;
    limit     = num_tests * 2000;
    repeat (limit) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst_i       = 1'b1;
    seed        = 32'h84ec_0e63;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    reset_test();
    alu_test();
    branch_test();
    memory_test();
    jump_test();
    halt_test();
    errors = errors + dut.u_req.u_props.fail_count;
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/cpu_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/register_file.sv
logic/cpu_core.sv
logic/request_unit.sv
logic/cpu_top.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

/* logic/alu.sv */
// Integer ALU with a separate branch comparator

`default_nettype none

module alu (
  input  cpu_pkg::alu_op_e op_i,
  input  cpu_pkg::word_t   a_i,
  input  cpu_pkg::word_t   b_i,
  input  logic [2:0]       cmp_i,
  output cpu_pkg::word_t   result_o,
  output logic             taken_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      cpu_pkg::ALU_ADD:    result_o = a_i + b_i;
      cpu_pkg::ALU_SUB:    result_o = a_i - b_i;
      cpu_pkg::ALU_SLL:    result_o = a_i << shamt;
      cpu_pkg::ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      cpu_pkg::ALU_SLTU:   result_o = {31'b0, a_i < b_i};
      cpu_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      cpu_pkg::ALU_SRL:    result_o = a_i >> shamt;
      cpu_pkg::ALU_SRA:    result_o = cpu_pkg::word_t'($signed(a_i) >>> shamt);
      cpu_pkg::ALU_OR:     result_o = a_i | b_i;
      cpu_pkg::ALU_AND:    result_o = a_i & b_i;
      cpu_pkg::ALU_PASS_B: result_o = b_i;
      default:             result_o = a_i + b_i;
    endcase
  end

  // Branch condition from funct3, independent of op_i
  always_comb begin
    case (cmp_i)
      3'b000:  taken_o = (a_i == b_i);
      3'b001:  taken_o = (a_i != b_i);
      3'b100:  taken_o = $signed(a_i) < $signed(b_i);
      3'b101:  taken_o = $signed(a_i) >= $signed(b_i);
      3'b110:  taken_o = a_i < b_i;
      3'b111:  taken_o = a_i >= b_i;
      default: taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/control_unit.sv */
// Instruction decoder producing the control word and sign-extended immediate

`default_nettype none

module control_unit (
  input  cpu_pkg::word_t     instr_i,
  output cpu_pkg::ctrl_t     ctrl_o,
  output cpu_pkg::reg_addr_t rs1_o,
  output cpu_pkg::reg_addr_t rs2_o,
  output cpu_pkg::reg_addr_t rd_o
);

  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic           alt;
  cpu_pkg::word_t imm_i;
  cpu_pkg::word_t imm_s;
  cpu_pkg::word_t imm_b;
  cpu_pkg::word_t imm_u;
  cpu_pkg::word_t imm_j;

  // Shared by OP and OP_IMM, sub_sra picks SUB or SRA
  function automatic cpu_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                       input logic       sub_sra);
    cpu_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = sub_sra ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
      3'b001:  op = cpu_pkg::ALU_SLL;
      3'b010:  op = cpu_pkg::ALU_SLT;
      3'b011:  op = cpu_pkg::ALU_SLTU;
      3'b100:  op = cpu_pkg::ALU_XOR;
      3'b101:  op = sub_sra ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
      3'b110:  op = cpu_pkg::ALU_OR;
      default: op = cpu_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign alt    = instr_i[30];

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  // Immediate formats
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    // Unknown opcodes fall through as no-ops
    ctrl_o        = '0;
    ctrl_o.alu_op = cpu_pkg::ALU_ADD;
    ctrl_o.funct3 = funct3;
    case (opcode)
      cpu_pkg::OPC_LUI: begin
        ctrl_o.alu_op    = cpu_pkg::ALU_PASS_B;
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.imm       = imm_u;
      end
      cpu_pkg::OPC_AUIPC: begin
        ctrl_o.a_pc      = 1'b1;
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.imm       = imm_u;
      end
      cpu_pkg::OPC_JAL: begin
        ctrl_o.jump      = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.imm       = imm_j;
      end
      cpu_pkg::OPC_JALR: begin
        ctrl_o.jump_reg  = 1'b1;
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.imm       = imm_i;
      end
      cpu_pkg::OPC_BRANCH: begin
        ctrl_o.branch = 1'b1;
        ctrl_o.imm    = imm_b;
      end
      cpu_pkg::OPC_LOAD: begin
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.mem_read  = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.imm       = imm_i;
      end
      cpu_pkg::OPC_STORE: begin
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.mem_write = 1'b1;
        ctrl_o.imm       = imm_s;
      end
      cpu_pkg::OPC_OP_IMM: begin
        // Bit 30 only matters for SRAI here
        ctrl_o.alu_op    = alu_from_funct3(funct3, alt && (funct3 == 3'b101));
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.imm       = imm_i;
      end
      cpu_pkg::OPC_OP: begin
        ctrl_o.alu_op    = alu_from_funct3(funct3, alt);
        ctrl_o.reg_write = 1'b1;
      end
      cpu_pkg::OPC_SYSTEM: begin
        // EBREAK has imm bit 0 set, ECALL does not
        ctrl_o.halt = (funct3 == 3'b000) && instr_i[20];
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
// Multicycle RV32I core: fetch, execute, memory and writeback, one instruction at a time

`default_nettype none

module cpu_core (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              req_ready_i,
  input  logic              rsp_valid_i,
  input  cpu_pkg::word_t    rsp_data_i,
  output logic              req_valid_o,
  output cpu_pkg::mem_req_t req_o,
  output logic              halt_o
);

  cpu_pkg::core_state_e state_q;
  cpu_pkg::word_t       pc_q;
  cpu_pkg::word_t       ir_q;
  cpu_pkg::word_t       alu_q;
  cpu_pkg::word_t       load_q;
  logic                 taken_q;
  logic                 req_valid_q;
  logic                 wait_q;
  logic                 rsp_done;

  cpu_pkg::ctrl_t       ctrl;
  cpu_pkg::reg_addr_t   rs1;
  cpu_pkg::reg_addr_t   rs2;
  cpu_pkg::reg_addr_t   rd;
  cpu_pkg::word_t       rd1;
  cpu_pkg::word_t       rd2;
  cpu_pkg::word_t       op_a;
  cpu_pkg::word_t       op_b;
  cpu_pkg::word_t       alu_res;
  logic                 taken;
  cpu_pkg::word_t       pc_plus4;
  cpu_pkg::word_t       next_pc;
  cpu_pkg::word_t       wd;
  logic                 we;

  control_unit u_ctrl (
    .instr_i (ir_q),
    .ctrl_o  (ctrl),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd)
  );

  register_file u_rf (
    .clk   (clk),
    .rst_i (rst_i),
    .we_i  (we),
    .rs1_i (rs1),
    .rs2_i (rs2),
    .rd_i  (rd),
    .wd_i  (wd),
    .rd1_o (rd1),
    .rd2_o (rd2)
  );

  assign op_a = ctrl.a_pc ? pc_q : rd1;
  assign op_b = ctrl.b_imm ? ctrl.imm : rd2;

  alu u_alu (
    .op_i     (ctrl.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .cmp_i    (ctrl.funct3),
    .result_o (alu_res),
    .taken_o  (taken)
  );

  assign pc_plus4 = pc_q + 32'd4;

  always_comb begin
    if (ctrl.jump_reg) begin
      next_pc = {alu_q[31:1], 1'b0};
    end else if (ctrl.jump || (ctrl.branch && taken_q)) begin
      next_pc = pc_q + ctrl.imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // Link address for jumps, else load data or ALU result
  assign wd = (ctrl.jump || ctrl.jump_reg) ? pc_plus4 : (ctrl.mem_read ? load_q : alu_q);
  assign we = (state_q == cpu_pkg::WRITEBACK) && ctrl.reg_write;

  // Instruction fetch in FETCH, data access in MEMORY
  always_comb begin
    if (state_q == cpu_pkg::MEMORY) begin
      req_o.addr  = alu_q;
      req_o.wdata = rd2;
      req_o.write = ctrl.mem_write;
    end else begin
      req_o.addr  = pc_q;
      req_o.wdata = '0;
      req_o.write = 1'b0;
    end
  end

  assign req_valid_o = req_valid_q;
  assign rsp_done    = wait_q && rsp_valid_i;
  assign halt_o      = (state_q == cpu_pkg::HALTED);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= cpu_pkg::FETCH;
      pc_q        <= cpu_pkg::RESET_PC;
      req_valid_q <= 1'b0;
      wait_q      <= 1'b0;
    end else begin
      case (state_q)
        cpu_pkg::FETCH, cpu_pkg::MEMORY: begin
          // Raise valid, hold until taken, then wait for the response
          if (req_valid_q) begin
            if (req_ready_i) begin
              req_valid_q <= 1'b0;
              wait_q      <= 1'b1;
            end
          end else if (wait_q) begin
            if (rsp_valid_i) begin
              wait_q  <= 1'b0;
              state_q <= (state_q == cpu_pkg::FETCH) ? cpu_pkg::EXECUTE : cpu_pkg::WRITEBACK;
            end
          end else begin
            req_valid_q <= 1'b1;
          end
        end
        cpu_pkg::EXECUTE: begin
          if (ctrl.halt) begin
            state_q <= cpu_pkg::HALTED;
          end else if (ctrl.mem_read || ctrl.mem_write) begin
            state_q <= cpu_pkg::MEMORY;
          end else begin
            state_q <= cpu_pkg::WRITEBACK;
          end
        end
        cpu_pkg::WRITEBACK: begin
          pc_q    <= next_pc;
          state_q <= cpu_pkg::FETCH;
        end
        default: ;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (rsp_done && (state_q == cpu_pkg::FETCH)) begin
      ir_q <= rsp_data_i;
    end
    if (rsp_done && (state_q == cpu_pkg::MEMORY)) begin
      load_q <= rsp_data_i;
    end
    if (state_q == cpu_pkg::EXECUTE) begin
      alu_q   <= alu_res;
      taken_q <= taken;
    end
  end

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
// Shared word types, opcodes, ALU and state encodings, and structs for the RV32I core

`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    FETCH,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALTED
  } core_state_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       a_pc;       // Operand a is the PC instead of rs1
    logic       b_imm;      // Operand b is the immediate instead of rs2
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic [2:0] funct3;     // Compare kind for branches
    logic       jump;
    logic       jump_reg;
    logic       halt;
    word_t      imm;
  } ctrl_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } mem_req_t;

endpackage

`default_nettype wire

/* logic/cpu_top.sv */
// Processor top level, core plus request unit on one memory bus

`default_nettype none

module cpu_top (
  input  logic           clk,
  input  logic           rst_i,
  input  logic           bus_busy_i,
  input  cpu_pkg::word_t bus_dat_i,
  output cpu_pkg::word_t bus_adr_o,
  output cpu_pkg::word_t bus_dat_o,
  output logic           bus_read_o,
  output logic           bus_write_o,
  output logic           halt_o
);

  cpu_pkg::mem_req_t core_req;
  logic              req_valid;
  logic              req_ready;
  logic              rsp_valid;
  cpu_pkg::word_t    rsp_data;

  cpu_core u_core (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_ready_i (req_ready),
    .rsp_valid_i (rsp_valid),
    .rsp_data_i  (rsp_data),
    .req_valid_o (req_valid),
    .req_o       (core_req),
    .halt_o      (halt_o)
  );

  request_unit u_req (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_i       (core_req),
    .bus_busy_i  (bus_busy_i),
    .bus_dat_i   (bus_dat_i),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data),
    .bus_adr_o   (bus_adr_o),
    .bus_dat_o   (bus_dat_o),
    .bus_read_o  (bus_read_o),
    .bus_write_o (bus_write_o)
  );

endmodule

`default_nettype wire

/* logic/register_file.sv */
// 32 x 32 integer register file, two async reads and one sync write

`default_nettype none

module register_file (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               we_i,
  input  cpu_pkg::reg_addr_t rs1_i,
  input  cpu_pkg::reg_addr_t rs2_i,
  input  cpu_pkg::reg_addr_t rd_i,
  input  cpu_pkg::word_t     wd_i,
  output cpu_pkg::word_t     rd1_o,
  output cpu_pkg::word_t     rd2_o
);

  cpu_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != 5'd0)) begin
      // x0 never written, so it reads back zero
      regs[rd_i] <= wd_i;
    end
  end

  assign rd1_o = regs[rs1_i];
  assign rd2_o = regs[rs2_i];

endmodule

`default_nettype wire

/* logic/request_unit.sv */
// Bridges core valid/ready requests onto the strobe and busy memory bus

`default_nettype none

module request_unit (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              req_valid_i,
  input  cpu_pkg::mem_req_t req_i,
  input  logic              bus_busy_i,
  input  cpu_pkg::word_t    bus_dat_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output cpu_pkg::word_t    rsp_data_o,
  output cpu_pkg::word_t    bus_adr_o,
  output cpu_pkg::word_t    bus_dat_o,
  output logic              bus_read_o,
  output logic              bus_write_o
);

  typedef enum logic [1:0] {
    RU_IDLE,
    RU_STROBE,
    RU_WAIT,
    RU_RESPOND
  } ru_state_e;

  ru_state_e         state_q;
  logic              busy_seen_q;
  cpu_pkg::mem_req_t req_q;
  cpu_pkg::word_t    rdata_q;

  assign req_ready_o = (state_q == RU_IDLE);
  assign rsp_valid_o = (state_q == RU_RESPOND);
  assign rsp_data_o  = rdata_q;

  // Address and data held in req_q for the whole transaction
  assign bus_adr_o   = req_q.addr;
  assign bus_dat_o   = req_q.wdata;
  assign bus_read_o  = (state_q == RU_STROBE) && !req_q.write;
  assign bus_write_o = (state_q == RU_STROBE) && req_q.write;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= RU_IDLE;
      busy_seen_q <= 1'b0;
    end else begin
      case (state_q)
        RU_IDLE: begin
          if (req_valid_i) begin
            state_q <= RU_STROBE;
          end
        end
        RU_STROBE: begin
          busy_seen_q <= 1'b0;
          state_q     <= RU_WAIT;
        end
        RU_WAIT: begin
          // Done on the first low busy after it has been high
          if (bus_busy_i) begin
            busy_seen_q <= 1'b1;
          end else if (busy_seen_q) begin
            state_q <= RU_RESPOND;
          end
        end
        default: begin
          state_q <= RU_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready_o && req_valid_i) begin
      req_q <= req_i;
    end
    if ((state_q == RU_WAIT) && busy_seen_q && !bus_busy_i) begin
      rdata_q <= bus_dat_i;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the RV32I testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module cpu_tb -o cpu_sim; then
  echo "build failed"
  exit 1
fi

if ! sim_out="$(./obj_dir/cpu_sim)"; then
  echo "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$sim_out"

if grep -qF '*** PASSED ***' <<< "$sim_out"; then
  exit 0
fi
exit 1
